// ==== design/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Data path word width
`define MIPS_DATA_W 32

// Register file addressing
`define MIPS_REG_AW 5
`define MIPS_NUM_REGS 32

// Primary opcode field in bits 31:26
`define MIPS_OP_W 6

`endif

// ==== design/mips_pkg.sv ====
`include "mips_macros.svh"

package mips_pkg;

    ////////////////////////////////////////////////////////////////////
    // Data path vectors
    ////////////////////////////////////////////////////////////////////

    typedef logic [`MIPS_DATA_W-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;
    typedef logic [`MIPS_OP_W-1:0]   opcode_t;

    ////////////////////////////////////////////////////////////////////
    // Control fields carried down the pipe
    ////////////////////////////////////////////////////////////////////

    // regdst [3], aluop [2:1], alusrc [0]
    typedef logic [3:0] ex_ctrl_t;

    // memread [2], memwrite [1], branch [0]
    typedef logic [2:0] mem_ctrl_t;

    // regwrite [1], memtoreg [0]
    typedef logic [1:0] wb_ctrl_t;

    // Opcodes handled by this stage
    typedef enum opcode_t {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } op_e;

endpackage

// ==== design/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if;
    import mips_pkg::*;

    ex_ctrl_t  ex;
    mem_ctrl_t mem;
    wb_ctrl_t  wb;
    // High selects beq, low selects bne
    logic      beq_or_bne;

    modport src (
        output ex,
        output mem,
        output wb,
        output beq_or_bne
    );

    modport dst (
        input ex,
        input mem,
        input wb,
        input beq_or_bne
    );

endinterface

// ==== design/main_control.sv ====
`timescale 1ns/1ps

module main_control (
    input  mips_pkg::opcode_t i_opcode,
    ctrl_if.src               ctrl
);
    import mips_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Opcode to control table
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        // Unsupported opcodes fall through as a bubble
        ctrl.ex         = '0;
        ctrl.mem        = '0;
        ctrl.wb         = '0;
        ctrl.beq_or_bne = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                // Destination from rd, ALU function from funct
                ctrl.ex  = 4'b1100;
                ctrl.mem = 3'b000;
                ctrl.wb  = 2'b10;
            end
            OP_LW: begin
                ctrl.ex  = 4'b0001;
                ctrl.mem = 3'b100;
                ctrl.wb  = 2'b11;
            end
            OP_SW: begin
                ctrl.ex  = 4'b0001;
                ctrl.mem = 3'b010;
                ctrl.wb  = 2'b00;
            end
            OP_BEQ: begin
                // Subtract to compare
                ctrl.ex         = 4'b0010;
                ctrl.mem        = 3'b001;
                ctrl.wb         = 2'b00;
                ctrl.beq_or_bne = 1'b1;
            end
            OP_BNE: begin
                ctrl.ex         = 4'b0010;
                ctrl.mem        = 3'b001;
                ctrl.wb         = 2'b00;
                ctrl.beq_or_bne = 1'b0;
            end
            OP_ADDI: begin
                // Add with immediate, result into rt
                ctrl.ex  = 4'b0001;
                ctrl.mem = 3'b000;
                ctrl.wb  = 2'b10;
            end
            default: begin
                ctrl.ex         = '0;
                ctrl.mem        = '0;
                ctrl.wb         = '0;
                ctrl.beq_or_bne = 1'b0;
            end
        endcase
    end

endmodule

// ==== design/reg_bank.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module reg_bank (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_regwrite,
    input  mips_pkg::reg_addr_t i_rs_addr,
    input  mips_pkg::reg_addr_t i_rt_addr,
    input  mips_pkg::reg_addr_t i_write_addr,
    input  mips_pkg::word_t     i_write_data,
    output mips_pkg::word_t     o_rega,
    output mips_pkg::word_t     o_regb
);
    import mips_pkg::*;

    word_t regs [`MIPS_NUM_REGS];

    logic wr_en;

    // Register zero is never written
    assign wr_en = i_regwrite && (i_write_addr != '0);

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_write_addr] <= i_write_data;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read ports with write-through bypass
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        if (i_rs_addr == '0)
            o_rega = '0;
        else if (wr_en && (i_write_addr == i_rs_addr))
            o_rega = i_write_data;
        else
            o_rega = regs[i_rs_addr];

        if (i_rt_addr == '0)
            o_regb = '0;
        else if (wr_en && (i_write_addr == i_rt_addr))
            o_regb = i_write_data;
        else
            o_regb = regs[i_rt_addr];
    end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic [15:0]     i_imm,
    input  mips_pkg::word_t i_pc,
    input  mips_pkg::word_t i_rega,
    input  mips_pkg::word_t i_regb,
    ctrl_if.dst             ctrl,
    output mips_pkg::word_t o_ext_imm,
    output mips_pkg::word_t o_pc_branch,
    output logic            o_branch_taken
);
    import mips_pkg::*;

    logic ops_equal;
    logic cond_met;

    // Sign extension of the 16-bit offset
    assign o_ext_imm = {{16{i_imm[15]}}, i_imm};

    // Word offset, so shift by two
    assign o_pc_branch = i_pc + (o_ext_imm << 2);

    ////////////////////////////////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////////////////////////////////

    assign ops_equal = (i_rega == i_regb);

    // beq wants equality, bne the opposite
    assign cond_met = ctrl.beq_or_bne ? ops_equal : !ops_equal;

    // Only the branch bit of the MEM field qualifies the decision
    assign o_branch_taken = ctrl.mem[0] && cond_met;

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                  i_clock,
    input  logic                  i_rst_n,
    // Upstream handshake
    input  logic                  i_valid,
    output logic                  o_ready,
    // Downstream handshake
    output logic                  o_valid,
    input  logic                  i_ready,
    ctrl_if.dst                   ctrl,
    input  mips_pkg::word_t       i_rega,
    input  mips_pkg::word_t       i_regb,
    input  mips_pkg::word_t       i_ext_imm,
    input  mips_pkg::word_t       i_pc_branch,
    input  logic                  i_branch_taken,
    input  mips_pkg::opcode_t     i_opcode,
    input  mips_pkg::reg_addr_t   i_rs,
    input  mips_pkg::reg_addr_t   i_rt,
    input  mips_pkg::reg_addr_t   i_rd,
    output mips_pkg::word_t       o_rega,
    output mips_pkg::word_t       o_regb,
    output mips_pkg::word_t       o_ext_imm,
    output mips_pkg::word_t       o_pc_branch,
    output logic                  o_branch_taken,
    output mips_pkg::opcode_t     o_opcode,
    output mips_pkg::reg_addr_t   o_rs,
    output mips_pkg::reg_addr_t   o_rt,
    output mips_pkg::reg_addr_t   o_rd,
    output mips_pkg::ex_ctrl_t    o_ex,
    output mips_pkg::mem_ctrl_t   o_mem,
    output mips_pkg::wb_ctrl_t    o_wb
);
    import mips_pkg::*;

    logic full;
    logic load;

    ////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////

    // Free slot, or the held item leaves this cycle
    assign o_ready = !full || i_ready;
    assign load    = i_valid && o_ready;
    assign o_valid = full;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (i_ready) begin
            full <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Payload
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (load) begin
            o_rega         <= i_rega;
            o_regb         <= i_regb;
            o_ext_imm      <= i_ext_imm;
            o_pc_branch    <= i_pc_branch;
            o_branch_taken <= i_branch_taken;
            o_opcode       <= i_opcode;
            o_rs           <= i_rs;
            o_rt           <= i_rt;
            o_rd           <= i_rd;
            o_ex           <= ctrl.ex;
            o_mem          <= ctrl.mem;
            o_wb           <= ctrl.wb;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode_stage (
    input  logic                  i_clock,
    input  logic                  i_rst_n,
    // Instruction in
    input  logic                  i_valid,
    output logic                  o_ready,
    input  mips_pkg::word_t       i_instr,
    input  mips_pkg::word_t       i_pc,
    // Write-back port
    input  logic                  i_regwrite,
    input  mips_pkg::reg_addr_t   i_write_addr,
    input  mips_pkg::word_t       i_write_data,
    // Decoded bundle out
    output logic                  o_valid,
    input  logic                  i_ready,
    output mips_pkg::word_t       o_rega,
    output mips_pkg::word_t       o_regb,
    output mips_pkg::word_t       o_ext_imm,
    output mips_pkg::word_t       o_pc_branch,
    output mips_pkg::opcode_t     o_opcode,
    output mips_pkg::reg_addr_t   o_rs,
    output mips_pkg::reg_addr_t   o_rt,
    output mips_pkg::reg_addr_t   o_rd,
    output mips_pkg::ex_ctrl_t    o_ex,
    output mips_pkg::mem_ctrl_t   o_mem,
    output mips_pkg::wb_ctrl_t    o_wb,
    output logic                  o_branch_taken
);
    import mips_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////

    opcode_t     opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;

    assign opcode = i_instr[`MIPS_DATA_W-1 -: `MIPS_OP_W];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign imm    = i_instr[15:0];

    word_t rega;
    word_t regb;
    word_t ext_imm;
    word_t pc_branch;
    logic  branch_taken;

    ctrl_if ctrl_bus ();

    main_control u_main_control (
        .i_opcode (opcode),
        .ctrl     (ctrl_bus.src)
    );

    reg_bank u_reg_bank (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_regwrite   (i_regwrite),
        .i_rs_addr    (rs),
        .i_rt_addr    (rt),
        .i_write_addr (i_write_addr),
        .i_write_data (i_write_data),
        .o_rega       (rega),
        .o_regb       (regb)
    );

    branch_unit u_branch_unit (
        .i_imm          (imm),
        .i_pc           (i_pc),
        .i_rega         (rega),
        .i_regb         (regb),
        .ctrl           (ctrl_bus.dst),
        .o_ext_imm      (ext_imm),
        .o_pc_branch    (pc_branch),
        .o_branch_taken (branch_taken)
    );

    // Single pipeline slot toward EX
    id_ex_reg u_id_ex_reg (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_valid),
        .o_ready        (o_ready),
        .o_valid        (o_valid),
        .i_ready        (i_ready),
        .ctrl           (ctrl_bus.dst),
        .i_rega         (rega),
        .i_regb         (regb),
        .i_ext_imm      (ext_imm),
        .i_pc_branch    (pc_branch),
        .i_branch_taken (branch_taken),
        .i_opcode       (opcode),
        .i_rs           (rs),
        .i_rt           (rt),
        .i_rd           (rd),
        .o_rega         (o_rega),
        .o_regb         (o_regb),
        .o_ext_imm      (o_ext_imm),
        .o_pc_branch    (o_pc_branch),
        .o_branch_taken (o_branch_taken),
        .o_opcode       (o_opcode),
        .o_rs           (o_rs),
        .o_rt           (o_rt),
        .o_rd           (o_rd),
        .o_ex           (o_ex),
        .o_mem          (o_mem),
        .o_wb           (o_wb)
    );

endmodule

// ==== testbench/decode_stage_chk.sv ====
`timescale 1ns/1ps

module decode_stage_chk (
    input logic                i_clock,
    input logic                i_rst_n,
    input logic                i_out_valid,
    input logic                i_out_ready,
    input logic                i_in_ready,
    input mips_pkg::word_t     i_rega,
    input mips_pkg::word_t     i_regb,
    input mips_pkg::word_t     i_ext_imm,
    input mips_pkg::word_t     i_pc_branch,
    input mips_pkg::opcode_t   i_opcode,
    input mips_pkg::reg_addr_t i_rs,
    input mips_pkg::reg_addr_t i_rt,
    input mips_pkg::reg_addr_t i_rd,
    input mips_pkg::ex_ctrl_t  i_ex,
    input mips_pkg::mem_ctrl_t i_mem,
    input mips_pkg::wb_ctrl_t  i_wb,
    input logic                i_branch_taken
);
    import mips_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Handshake rules of the ID/EX slot
    //////////////////////////////////////////////////////////////////////

    // Reset empties the slot
    a_valid_after_reset: assert property (
        @(posedge i_clock) !i_rst_n |=> !i_out_valid
    ) else $error("o_valid was high in the cycle after reset");

    // Stalled bundle must not move
    a_hold_under_stall: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (i_out_valid && !i_out_ready) |=> i_out_valid &&
            $stable({i_rega, i_regb, i_ext_imm, i_pc_branch, i_opcode, i_rs, i_rt, i_rd,
                     i_ex, i_mem, i_wb, i_branch_taken})
    ) else $error("Outputs changed while stalled by i_ready");

    a_ready_when_empty: assert property (
        @(posedge i_clock) disable iff (!i_rst_n) !i_out_valid |-> i_in_ready
    ) else $error("o_ready low while the slot is empty");

endmodule

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_decode_stage;
    import mips_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 50;

    // Expected control words
    localparam ex_ctrl_t  EX_R   = 4'b1100;
    localparam ex_ctrl_t  EX_IMM = 4'b0001;
    localparam ex_ctrl_t  EX_BR  = 4'b0010;
    localparam mem_ctrl_t MEM_LW = 3'b100;
    localparam mem_ctrl_t MEM_SW = 3'b010;
    localparam mem_ctrl_t MEM_BR = 3'b001;

    typedef struct packed {
        word_t     instr;
        word_t     pc;
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        logic      taken;
    } test_t;

    // One expected ID/EX transfer, operands taken from the model
    typedef struct packed {
        test_t t;
        word_t rega;
        word_t regb;
    } expect_t;

    logic      i_clock = 1'b0;
    logic      i_ready = 1'b0;
    logic      i_rst_n;
    logic      i_valid;
    logic      o_ready;
    word_t     i_instr;
    word_t     i_pc;
    logic      i_regwrite;
    reg_addr_t i_write_addr;
    word_t     i_write_data;
    logic      o_valid;
    word_t     o_rega, o_regb, o_ext_imm, o_pc_branch;
    opcode_t   o_opcode;
    reg_addr_t o_rs, o_rt, o_rd;
    ex_ctrl_t  o_ex;
    mem_ctrl_t o_mem;
    wb_ctrl_t  o_wb;
    logic      o_branch_taken;

    test_t   tests [NUM_TESTS];
    word_t   model_regs [`MIPS_NUM_REGS];
    expect_t exp_q [$];
    expect_t exp_item;
    int      out_count = 0;

    decode_stage UUT (.*);

    bind decode_stage decode_stage_chk u_decode_stage_chk (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_out_valid    (o_valid),
        .i_out_ready    (i_ready),
        .i_in_ready     (o_ready),
        .i_rega         (o_rega),
        .i_regb         (o_regb),
        .i_ext_imm      (o_ext_imm),
        .i_pc_branch    (o_pc_branch),
        .i_opcode       (o_opcode),
        .i_rs           (o_rs),
        .i_rt           (o_rt),
        .i_rd           (o_rd),
        .i_ex           (o_ex),
        .i_mem          (o_mem),
        .i_wb           (o_wb),
        .i_branch_taken (o_branch_taken)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // Random back-pressure, ready about three cycles in four
    always @(posedge i_clock) begin
        i_ready <= ($urandom % 4) != 0;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t encode_itype(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // add rd, rs, rt
    function automatic word_t encode_rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
        return {6'h00, rs, rt, rd, 5'd0, 6'h20};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    // Hold the instruction until the stage accepts it
    task automatic issue(input test_t t);
        i_valid <= 1'b1;
        i_instr <= t.instr;
        i_pc    <= t.pc;
        do begin
            @(negedge i_clock);
        end while (!o_ready);
        @(posedge i_clock);
        exp_q.push_back('{t, model_regs[t.instr[25:21]], model_regs[t.instr[20:16]]});
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        i_regwrite   <= 1'b1;
        i_write_addr <= addr;
        i_write_data <= data;
        @(posedge i_clock);
        // Register zero stays zero
        if (addr != '0) begin
            model_regs[addr] = data;
        end
    endtask

    // r10 and r11 end up equal, r12 always differs from both
    task automatic load_table();
        tests[0]  = '{encode_rtype(5'd1, 5'd2, 5'd3), 32'h40, EX_R, 3'b000, 2'b10, 1'b0};
        tests[1]  = '{encode_itype(OP_LW, 5'd4, 5'd5, 16'h0010), 32'h44, EX_IMM, MEM_LW,
                      2'b11, 1'b0};
        tests[2]  = '{encode_itype(OP_SW, 5'd6, 5'd7, 16'hFFFC), 32'h48, EX_IMM, MEM_SW,
                      2'b00, 1'b0};
        tests[3]  = '{encode_itype(OP_ADDI, 5'd8, 5'd9, 16'h7FFF), 32'h4C, EX_IMM, 3'b000,
                      2'b10, 1'b0};
        tests[4]  = '{encode_itype(OP_BEQ, 5'd10, 5'd11, 16'h0004), 32'h100, EX_BR, MEM_BR,
                      2'b00, 1'b1};
        tests[5]  = '{encode_itype(OP_BEQ, 5'd10, 5'd12, 16'hFFF8), 32'h200, EX_BR, MEM_BR,
                      2'b00, 1'b0};
        tests[6]  = '{encode_itype(OP_BNE, 5'd10, 5'd11, 16'h0020), 32'h300, EX_BR, MEM_BR,
                      2'b00, 1'b0};
        tests[7]  = '{encode_itype(OP_BNE, 5'd11, 5'd12, 16'h8000), 32'h0040_0000, EX_BR,
                      MEM_BR, 2'b00, 1'b1};
        tests[8]  = '{encode_itype(OP_BEQ, 5'd0, 5'd0, 16'h0001), 32'h500, EX_BR, MEM_BR,
                      2'b00, 1'b1};
        tests[9]  = '{encode_itype(6'h02, 5'd3, 5'd4, 16'h1000), 32'h600, '0, '0, '0, 1'b0};
        tests[10] = '{encode_itype(6'h3F, 5'd10, 5'd11, 16'hFFFF), 32'h604, '0, '0, '0, 1'b0};
        tests[11] = '{encode_rtype(5'd10, 5'd11, 5'd31), 32'h608, EX_R, 3'b000, 2'b10, 1'b0};
        tests[12] = '{encode_itype(OP_LW, 5'd0, 5'd31, 16'h8001), 32'h60C, EX_IMM, MEM_LW,
                      2'b11, 1'b0};
        tests[13] = '{encode_itype(OP_ADDI, 5'd31, 5'd0, 16'hFFFF), 32'h610, EX_IMM, 3'b000,
                      2'b10, 1'b0};
        tests[14] = '{encode_itype(OP_SW, 5'd11, 5'd12, 16'h1234), 32'h614, EX_IMM, MEM_SW,
                      2'b00, 1'b0};
        tests[15] = '{encode_itype(OP_BNE, 5'd12, 5'd12, 16'h0008), 32'h618, EX_BR, MEM_BR,
                      2'b00, 1'b0};
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output checker, one table row per o_valid && i_ready transfer
    //////////////////////////////////////////////////////////////////////

    always @(negedge i_clock) begin
        if (i_rst_n && o_valid && i_ready) begin
            if (out_count >= exp_q.size()) begin
                stop_with_failure("The stage handed on an output with nothing outstanding");
            end else begin
                exp_item = exp_q[out_count];
                check_value(o_rega, exp_item.rega, "o_rega");
                check_value(o_regb, exp_item.regb, "o_regb");
                check_value(o_ext_imm, 32'($signed(exp_item.t.instr[15:0])), "o_ext_imm");
                check_value(o_pc_branch, exp_item.t.pc + {{14{exp_item.t.instr[15]}},
                            exp_item.t.instr[15:0], 2'b00}, "o_pc_branch");
                check_value(32'(o_opcode), 32'(exp_item.t.instr[31:26]), "o_opcode");
                check_value(32'(o_rs), 32'(exp_item.t.instr[25:21]), "o_rs");
                check_value(32'(o_rt), 32'(exp_item.t.instr[20:16]), "o_rt");
                check_value(32'(o_rd), 32'(exp_item.t.instr[15:11]), "o_rd");
                check_value(32'(o_ex), 32'(exp_item.t.ex), "o_ex");
                check_value(32'(o_mem), 32'(exp_item.t.mem), "o_mem");
                check_value(32'(o_wb), 32'(exp_item.t.wb), "o_wb");
                check_value(32'(o_branch_taken), 32'(exp_item.t.taken), "o_branch_taken");
                out_count = out_count + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        stop_with_failure("Timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        void'($urandom(78516));
        i_rst_n      <= 1'b0;
        i_valid      <= 1'b0;
        i_instr      <= '0;
        i_pc         <= '0;
        i_regwrite   <= 1'b0;
        i_write_addr <= '0;
        i_write_data <= '0;
        for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        load_table();

        repeat (RESET_CYCLES) @(posedge i_clock);
        i_rst_n <= 1'b1;
        @(negedge i_clock);
        check_value(32'(o_valid), 32'd0, "o_valid after reset");
        @(posedge i_clock);

        // Every register pair reads zero straight after reset
        for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
            issue('{encode_rtype(reg_addr_t'(r), reg_addr_t'(31 - r), reg_addr_t'(r)),
                    word_t'(r * 4), EX_R, 3'b000, 2'b10, 1'b0});
        end
        i_valid <= 1'b0;

        // Write-back port, register zero included
        for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
            write_reg(reg_addr_t'(r), $urandom | 32'h1);
        end
        write_reg(5'd11, model_regs[10]);
        write_reg(5'd12, model_regs[10] ^ 32'h1);
        i_regwrite <= 1'b0;

        // Read of r20 in the cycle it is written takes the new data
        @(negedge i_clock);
        while (o_valid) @(negedge i_clock);
        @(posedge i_clock);
        i_regwrite   <= 1'b1;
        i_write_addr <= 5'd20;
        i_write_data <= ~model_regs[20];
        model_regs[20] = ~model_regs[20];
        issue('{encode_rtype(5'd20, 5'd20, 5'd21), 32'h700, EX_R, 3'b000, 2'b10, 1'b0});
        i_regwrite <= 1'b0;

        for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
            issue('{encode_rtype(reg_addr_t'(r), reg_addr_t'(r + 7), reg_addr_t'(r)),
                    word_t'(32'h1000 + r * 4), EX_R, 3'b000, 2'b10, 1'b0});
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            issue(tests[i]);
        end
        i_valid <= 1'b0;

        while (out_count < exp_q.size()) @(posedge i_clock);
        repeat (2) @(posedge i_clock);
        if (o_valid) begin
            stop_with_failure("The stage still holds an item after the last transfer");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+design
design/mips_pkg.sv
design/ctrl_if.sv
design/main_control.sv
design/reg_bank.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/decode_stage.sv
testbench/decode_stage_chk.sv
testbench/tb_decode_stage.sv

// ==== Makefile ====
TOP := tb_decode_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
